//--- hdl/hisPkg.sv
`default_nettype none

package hisPkg;

    // raw TDC code width
    localparam int tsW = 10;
    // 16 bins per histogram
    localparam int binW = 4;
    // fine bin spans 4 codes
    localparam int fineShift = 2;

    typedef logic [tsW-1:0]  timeStamp_t;
    typedef logic [binW-1:0] binAddr_t;

    // which histogram is being built and scanned
    typedef enum logic {
        phCoarse,
        phFine
    } hisPhase_t;

    // one master's wishbone request to the bin RAM
    // count sits in the low bits of dat
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        binAddr_t    adr;
        logic [15:0] dat;
    } ramReq_t;

    // slave response, read data valid with ack
    typedef struct packed {
        logic        ack;
        logic [15:0] dat;
    } ramRsp_t;

    typedef struct packed {
        binAddr_t   coarseBin;
        binAddr_t   fineBin;
        timeStamp_t peakTime;
    } peakResult_t;

endpackage

`default_nettype wire

//--- hdl/binFolder.sv
`timescale 1ns/1ps
`default_nettype none

module binFolder import hisPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  hisPhase_t  phase,
    input  timeStamp_t smpDat,
    input  logic       winLoad,
    input  binAddr_t   winBin,
    output binAddr_t   binAddr,
    output logic       inWindow,
    output timeStamp_t winBase
);

    // fine window covers 16 bins of 4 codes
    localparam int winSpan = 1 << (binW + fineShift);

    timeStamp_t winOffset;

    // offset of the sample inside the fine window
    // wraps below the base, so the range check catches it
    assign winOffset = smpDat - winBase;

    always_comb begin
        if (phase == phCoarse) begin
            // coarse bin is just the top bits
            binAddr  = smpDat[tsW-1 -: binW];
            inWindow = 1'b1;
        end else begin
            binAddr  = winOffset[fineShift +: binW];
            inWindow = winOffset < timeStamp_t'(winSpan);
        end
    end

    // window base is the coarse peak bin times 64
    // highest base plus span still fits in tsW, no wrap
    always_ff @(posedge clk) begin
        if (rst) begin
            winBase <= '0;
        end else if (winLoad) begin
            winBase <= timeStamp_t'(winBin) << (tsW - binW);
        end
    end

endmodule

`default_nettype wire

//--- hdl/hisBuilder.sv
`timescale 1ns/1ps
`default_nettype none

module hisBuilder import hisPkg::*; #(
    parameter int countW        = 8,
    parameter int samplesPerHis = 64
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      smpCyc,
    input  logic      smpStb,
    input  binAddr_t  binAddr,
    input  logic      inWindow,
    input  ramRsp_t   bldRsp,
    input  logic      scanDone,
    output logic      smpAck,
    output ramReq_t   bldReq,
    output hisPhase_t phase,
    output logic      hisFull
);

    localparam int cntW = $clog2(samplesPerHis + 1);

    typedef enum logic [1:0] {
        stIdle,
        stRead,
        stWrite,
        stWaitScan
    } bldState_t;

    bldState_t         state;
    logic [cntW-1:0]   smpCnt;
    logic [countW-1:0] rdCount;
    logic [countW-1:0] incCount;
    logic              discardAck;
    logic              smpReq;
    logic              discard;
    logic              smpDone;
    logic              lastSmp;

    // ignore the strobe still held in the cycle of a discard ack
    assign smpReq  = smpCyc & smpStb & ~discardAck;
    assign discard = (state == stIdle) & smpReq & ~inWindow;
    assign rdCount = bldRsp.dat[countW-1:0];

    // sample finished, either dropped or written back
    assign smpDone = discard | ((state == stWrite) & bldRsp.ack);
    assign lastSmp = smpCnt == cntW'(samplesPerHis - 1);

    // binned sample acks with the write ack, dropped one a cycle later
    assign smpAck = discardAck | ((state == stWrite) & bldRsp.ack);

    always_comb begin
        bldReq     = '0;
        bldReq.adr = binAddr;
        bldReq.dat = 16'(incCount);
        // cyc stays up across read and write so the grant holds
        if (state == stRead || state == stWrite) begin
            bldReq.cyc = 1'b1;
            bldReq.stb = 1'b1;
            bldReq.we  = state == stWrite;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= stIdle;
            phase      <= phCoarse;
            smpCnt     <= '0;
            discardAck <= 1'b0;
            hisFull    <= 1'b0;
        end else begin
            discardAck <= discard;
            hisFull    <= smpDone & lastSmp;
            if (smpDone) begin
                smpCnt <= lastSmp ? '0 : smpCnt + 1'b1;
            end
            case (state)
                stIdle: begin
                    if (smpReq && inWindow) begin
                        state <= stRead;
                    end else if (discard && lastSmp) begin
                        state <= stWaitScan;
                    end
                end
                stRead: begin
                    if (bldRsp.ack) begin
                        state <= stWrite;
                    end
                end
                stWrite: begin
                    if (bldRsp.ack) begin
                        state <= lastSmp ? stWaitScan : stIdle;
                    end
                end
                default: begin
                    // histogram full, samples wait for the scan
                    if (scanDone) begin
                        phase <= (phase == phCoarse) ? phFine : phCoarse;
                        state <= stIdle;
                    end
                end
            endcase
        end
    end

    // saturating increment of the count just read
    always_ff @(posedge clk) begin
        if (state == stRead && bldRsp.ack) begin
            incCount <= (rdCount == '1) ? rdCount : rdCount + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/peakDetector.sv
`timescale 1ns/1ps
`default_nettype none

module peakDetector import hisPkg::*; #(
    parameter int countW = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        hisFull,
    input  hisPhase_t   phase,
    input  timeStamp_t  winBase,
    input  ramRsp_t     detRsp,
    output ramReq_t     detReq,
    output logic        scanDone,
    output logic        winLoad,
    output binAddr_t    winBin,
    output peakResult_t result,
    output logic        resultValid
);

    typedef enum logic [1:0] {
        stIdle,
        stRead,
        stClear
    } detState_t;

    detState_t         state;
    binAddr_t          idx;
    binAddr_t          bestBin;
    logic [countW-1:0] bestCnt;
    logic [countW-1:0] rdCount;
    logic              lastBin;
    logic              scanEnd;

    assign rdCount = detRsp.dat[countW-1:0];
    assign lastBin = idx == '1;

    // clearing write of bin 15 acked
    assign scanEnd = (state == stClear) & detRsp.ack & lastBin;

    always_comb begin
        detReq     = '0;
        // cyc held for the whole scan, one grant for all 32 transfers
        detReq.cyc = state != stIdle;
        detReq.stb = state != stIdle;
        detReq.we  = state == stClear;
        detReq.adr = idx;
        // clearing writes always carry zero
        detReq.dat = '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= stIdle;
            idx         <= '0;
            scanDone    <= 1'b0;
            winLoad     <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            scanDone    <= scanEnd;
            winLoad     <= scanEnd & (phase == phCoarse);
            resultValid <= scanEnd & (phase == phFine);
            case (state)
                stIdle: begin
                    if (hisFull) begin
                        idx   <= '0;
                        state <= stRead;
                    end
                end
                stRead: begin
                    if (detRsp.ack) begin
                        state <= stClear;
                    end
                end
                default: begin
                    if (detRsp.ack) begin
                        // wraps to 0 after the last bin
                        idx   <= idx + 1'b1;
                        state <= lastBin ? stIdle : stRead;
                    end
                end
            endcase
        end
    end

    // running maximum
    // strictly greater replaces, so the lowest index keeps a tie
    always_ff @(posedge clk) begin
        if (state == stIdle && hisFull) begin
            bestCnt <= '0;
            bestBin <= '0;
        end else if (state == stRead && detRsp.ack && rdCount > bestCnt) begin
            bestCnt <= rdCount;
            bestBin <= idx;
        end
    end

    always_ff @(posedge clk) begin
        if (scanEnd) begin
            if (phase == phCoarse) begin
                // also serves as the stored coarse peak during the fine pass
                winBin <= bestBin;
            end else begin
                result.coarseBin <= winBin;
                result.fineBin   <= bestBin;
                result.peakTime  <= winBase + (timeStamp_t'(bestBin) << fineShift);
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/binRamArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module binRamArbiter import hisPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  ramReq_t bldReq,
    input  ramReq_t detReq,
    input  ramRsp_t ramRsp,
    output ramRsp_t bldRsp,
    output ramRsp_t detRsp,
    output ramReq_t ramReq
);

    typedef enum logic [1:0] {
        ownIdle,
        ownBld,
        ownDet
    } owner_t;

    owner_t owner;
    logic   bldGnt;
    logic   detGnt;

    assign bldGnt = owner == ownBld;
    assign detGnt = owner == ownDet;

    // grant is taken on cyc and kept until that master drops cyc
    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= ownIdle;
        end else begin
            case (owner)
                ownIdle: begin
                    // detector first, its scan blocks the builder anyway
                    if (detReq.cyc) begin
                        owner <= ownDet;
                    end else if (bldReq.cyc) begin
                        owner <= ownBld;
                    end
                end
                ownBld: begin
                    if (!bldReq.cyc) begin
                        owner <= ownIdle;
                    end
                end
                default: begin
                    if (!detReq.cyc) begin
                        owner <= ownIdle;
                    end
                end
            endcase
        end
    end

    // idle bus presents no strobe
    always_comb begin
        ramReq = '0;
        if (bldGnt) begin
            ramReq = bldReq;
        end else if (detGnt) begin
            ramReq = detReq;
        end
    end

    // read data goes to both, ack only to the owner
    always_comb begin
        bldRsp     = ramRsp;
        bldRsp.ack = ramRsp.ack & bldGnt;
        detRsp     = ramRsp;
        detRsp.ack = ramRsp.ack & detGnt;
    end

endmodule

`default_nettype wire

//--- hdl/binRam.sv
`timescale 1ns/1ps
`default_nettype none

module binRam import hisPkg::*; #(
    parameter int countW = 8
) (
    input  logic    clk,
    input  logic    rst,
    input  ramReq_t ramReq,
    output ramRsp_t ramRsp
);

    localparam int depth = 1 << binW;

    logic [countW-1:0] mem [depth];
    logic [15:0]       rdDat;
    logic              ackQ;
    logic              xfer;

    // new transfer only when no ack is out, so ack gaps by a cycle
    assign xfer = ramReq.cyc & ramReq.stb & ~ackQ;

    always_ff @(posedge clk) begin
        if (rst) begin
            ackQ <= 1'b0;
            // all bins start empty
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
        end else begin
            ackQ <= xfer;
            if (xfer && ramReq.we) begin
                mem[ramReq.adr] <= ramReq.dat[countW-1:0];
            end
        end
    end

    // read data lines up with the ack
    always_ff @(posedge clk) begin
        if (xfer) begin
            rdDat <= 16'(mem[ramReq.adr]);
        end
    end

    assign ramRsp = '{ack: ackQ, dat: rdDat};

endmodule

`default_nettype wire

//--- hdl/peakTop.sv
`timescale 1ns/1ps
`default_nettype none

module peakTop import hisPkg::*; #(
    parameter int countW        = 8,
    parameter int samplesPerHis = 64
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        smpCyc,
    input  logic        smpStb,
    input  timeStamp_t  smpDat,
    output logic        smpAck,
    output peakResult_t result,
    output logic        resultValid
);

    // folding
    binAddr_t   binAddr;
    logic       inWindow;
    timeStamp_t winBase;

    // phase handshake
    hisPhase_t  phase;
    logic       hisFull;
    logic       scanDone;
    logic       winLoad;
    binAddr_t   winBin;

    // bin RAM bus
    ramReq_t    bldReq;
    ramReq_t    detReq;
    ramReq_t    ramReq;
    ramRsp_t    bldRsp;
    ramRsp_t    detRsp;
    ramRsp_t    ramRsp;

    binFolder folderU0 (
        .clk     (clk),
        .rst     (rst),
        .phase   (phase),
        .smpDat  (smpDat),
        .winLoad (winLoad),
        .winBin  (winBin),
        .binAddr (binAddr),
        .inWindow(inWindow),
        .winBase (winBase)
    );

    hisBuilder #(
        .countW       (countW),
        .samplesPerHis(samplesPerHis)
    ) builderU0 (
        .clk     (clk),
        .rst     (rst),
        .smpCyc  (smpCyc),
        .smpStb  (smpStb),
        .binAddr (binAddr),
        .inWindow(inWindow),
        .bldRsp  (bldRsp),
        .scanDone(scanDone),
        .smpAck  (smpAck),
        .bldReq  (bldReq),
        .phase   (phase),
        .hisFull (hisFull)
    );

    peakDetector #(
        .countW(countW)
    ) detectorU0 (
        .clk        (clk),
        .rst        (rst),
        .hisFull    (hisFull),
        .phase      (phase),
        .winBase    (winBase),
        .detRsp     (detRsp),
        .detReq     (detReq),
        .scanDone   (scanDone),
        .winLoad    (winLoad),
        .winBin     (winBin),
        .result     (result),
        .resultValid(resultValid)
    );

    binRamArbiter arbiterU0 (
        .clk   (clk),
        .rst   (rst),
        .bldReq(bldReq),
        .detReq(detReq),
        .ramRsp(ramRsp),
        .bldRsp(bldRsp),
        .detRsp(detRsp),
        .ramReq(ramReq)
    );

    binRam #(
        .countW(countW)
    ) ramU0 (
        .clk   (clk),
        .rst   (rst),
        .ramReq(ramReq),
        .ramRsp(ramRsp)
    );

endmodule

`default_nettype wire

//--- tests/peakTop_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module arbiterAsserts import hisPkg::*; (
    input logic    clk,
    input logic    rst,
    input logic    bldGnt,
    input logic    detGnt,
    input ramReq_t bldReq,
    input ramReq_t detReq,
    input ramReq_t ramReq,
    input ramRsp_t ramRsp
);

    logic busStb;

    // strobe as seen by the bin RAM
    assign busStb = ramReq.cyc & ramReq.stb;

    // one owner at a time
    // granted master keeps the bus while its cyc is up, the other never cuts in
    grantHeld: assert property (
        @(posedge clk) disable iff (rst)
            ((bldGnt && bldReq.cyc) || (detGnt && detReq.cyc))
            |=> $stable({bldGnt, detGnt})
    ) else $error("bin RAM grant moved while its master still held cyc");

    // slave never acks unprompted
    ackAfterStb: assert property (
        @(posedge clk) disable iff (rst) ramRsp.ack |-> $past(busStb)
    ) else $error("bin RAM ack without a preceding strobe");

    // a strobe stays up until its ack
    stbHeld: assert property (
        @(posedge clk) disable iff (rst) (busStb && !ramRsp.ack) |=> busStb
    ) else $error("bin RAM strobe dropped before its ack");

endmodule

bind binRamArbiter arbiterAsserts arbAssertsU0 (
    .clk   (clk),
    .rst   (rst),
    .bldGnt(bldGnt),
    .detGnt(detGnt),
    .bldReq(bldReq),
    .detReq(detReq),
    .ramReq(ramReq),
    .ramRsp(ramRsp)
);

`default_nettype wire

//--- tests/peakTopTb.sv
`timescale 1ns/1ps
`default_nettype none

module peakTopTb import hisPkg::*; ();

    localparam int countW         = 5;
    localparam int samplesPerHis  = 64;
    localparam int numAcq         = 8;
    localparam int smpPerAcq      = 2 * samplesPerHis;
    localparam int totalSmp       = numAcq * smpPerAcq;
    localparam int clkPeriod      = 8;
    // 128 samples per acquisition, at most 8 cycles each, plus slack
    localparam int watchdogCycles = numAcq * 128 * 8 + 200;

    logic        clk;
    logic        rst;
    logic        smpCyc;
    logic        smpStb;
    timeStamp_t  smpDat;
    logic        smpAck;
    peakResult_t result;
    logic        resultValid;

    // whole sample stream, coarse half then fine half per acquisition
    timeStamp_t  smpMem [totalSmp];
    logic [31:0] lfsr;
    int          errCount;
    int          resCount;
    int          ackCount;

    peakTop #(
        .countW       (countW),
        .samplesPerHis(samplesPerHis)
    ) DUT (
        .clk        (clk),
        .rst        (rst),
        .smpCyc     (smpCyc),
        .smpStb     (smpStb),
        .smpDat     (smpDat),
        .smpAck     (smpAck),
        .result     (result),
        .resultValid(resultValid)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one step per bit taken
    function logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsrStep(lfsr);
        end
        return v;
    endfunction

    // code inside a coarse bin and fine bin, random low bits
    function timeStamp_t codeAt(input int coarseBin, input int fineBin, input int jitterW);
        return timeStamp_t'(coarseBin * 64 + fineBin * 4) + timeStamp_t'(randBits(jitterW));
    endfunction

    function timeStamp_t clusterCode(input timeStamp_t centre);
        logic [31:0] spread;
        // one sample in four is uniform noise
        if (randBits(2) == 0) begin
            return timeStamp_t'(randBits(tsW));
        end
        // triangular spread of +-15 codes
        spread = randBits(4) + randBits(4);
        return centre + timeStamp_t'(spread) - timeStamp_t'(15);
    endfunction

    task automatic fillAcq(input int acq);
        int         base;
        int         j;
        logic       fine;
        timeStamp_t centre;
        base   = acq * smpPerAcq;
        centre = timeStamp_t'(randBits(tsW));
        for (int i = 0; i < smpPerAcq; i++) begin
            j    = i % samplesPerHis;
            fine = i >= samplesPerHis;
            case (acq)
                4: begin
                    // clusters of 30 in coarse bins 3 and 9, fine bins 5 and 11
                    if (j >= 60) begin
                        smpMem[base + i] = fine ? codeAt(3, 0, 2) : codeAt(12, 0, 6);
                    end else if (fine) begin
                        smpMem[base + i] = codeAt(3, (j % 2 == 1) ? 5 : 11, 2);
                    end else begin
                        smpMem[base + i] = codeAt((j % 2 == 1) ? 3 : 9, 0, 6);
                    end
                end
                5: begin
                    // most fine samples sit in coarse bin 1, outside the bin 6 window
                    if (fine) begin
                        smpMem[base + i] = (j % 4 == 0) ? codeAt(6, 2, 2) : codeAt(1, 7, 2);
                    end else if (j < 50) begin
                        smpMem[base + i] = codeAt(6, 0, 6);
                    end else begin
                        smpMem[base + i] = timeStamp_t'(randBits(tsW));
                    end
                end
                6: begin
                    // 32 hits in each of two bins, past the 5-bit limit
                    if (fine) begin
                        smpMem[base + i] = codeAt(5, (j % 2 == 1) ? 4 : 13, 2);
                    end else begin
                        smpMem[base + i] = codeAt((j % 2 == 1) ? 5 : 12, 0, 6);
                    end
                end
                default: smpMem[base + i] = clusterCode(centre);
            endcase
        end
    endtask

    // fullest bin, first one kept on a tie
    function automatic binAddr_t pickBin(input int cnt [16]);
        int       best;
        binAddr_t bin;
        best = 0;
        bin  = '0;
        for (int b = 0; b < 16; b++) begin
            if (cnt[b] > best) begin
                best = cnt[b];
                bin  = binAddr_t'(b);
            end
        end
        return bin;
    endfunction

    function automatic peakResult_t refPeak(input int base);
        int          coarseCnt [16];
        int          fineCnt [16];
        int          cap;
        int          winLo;
        int          code;
        peakResult_t expRes;
        cap = (1 << countW) - 1;
        for (int b = 0; b < 16; b++) begin
            coarseCnt[b] = 0;
            fineCnt[b]   = 0;
        end
        // 64 codes per coarse bin
        for (int i = 0; i < samplesPerHis; i++) begin
            code = int'(smpMem[base + i]) / 64;
            if (coarseCnt[code] < cap) begin
                coarseCnt[code]++;
            end
        end
        expRes.coarseBin = pickBin(coarseCnt);
        winLo = int'(expRes.coarseBin) * 64;
        // fine bins of 4 codes, only inside the window
        for (int i = 0; i < samplesPerHis; i++) begin
            code = int'(smpMem[base + samplesPerHis + i]) - winLo;
            if (code >= 0 && code < 64 && fineCnt[code / 4] < cap) begin
                fineCnt[code / 4]++;
            end
        end
        expRes.fineBin  = pickBin(fineCnt);
        expRes.peakTime = timeStamp_t'(winLo + int'(expRes.fineBin) * 4);
        return expRes;
    endfunction

    task checkVal(input string name, input logic [31:0] got, input logic [31:0] expVal);
        if (got !== expVal) begin
            errCount++;
            $display("Error: %s got 0x%0h expected 0x%0h", name, got, expVal);
        end
    endtask

    initial begin : mainProc
        smpCyc   = 1'b0;
        smpStb   = 1'b0;
        smpDat   = '0;
        rst      = 1'b1;
        errCount = 0;
        resCount = 0;
        ackCount = 0;
        lfsr     = 32'h1eba;
        for (int a = 0; a < numAcq; a++) begin
            fillAcq(a);
        end
        repeat (2) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < totalSmp; i++) begin
            // occasional idle cycle between samples
            if (randBits(2) == 0) begin
                smpCyc = 1'b0;
                smpStb = 1'b0;
                @(negedge clk);
            end
            smpCyc = 1'b1;
            smpStb = 1'b1;
            smpDat = smpMem[i];
            // held through any scan until acked
            do begin
                @(negedge clk);
            end while (!smpAck);
            @(negedge clk);
        end
        smpCyc = 1'b0;
        smpStb = 1'b0;
        while (resCount < numAcq) begin
            @(negedge clk);
        end
        // room for a stray extra result
        repeat (20) @(negedge clk);
        checkVal("smpAck count", 32'(ackCount), 32'(totalSmp));
        $display("%0d errors in %0d results", errCount, resCount);
        if (errCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : compareProc
        peakResult_t expRes;
        forever begin
            @(negedge clk);
            if (!rst && resultValid) begin
                if (resCount >= numAcq) begin
                    errCount++;
                    $display("result pulse with no acquisition left to match it");
                end else begin
                    expRes = refPeak(resCount * smpPerAcq);
                    checkVal("result.coarseBin", 32'(result.coarseBin), 32'(expRes.coarseBin));
                    checkVal("result.fineBin", 32'(result.fineBin), 32'(expRes.fineBin));
                    checkVal("result.peakTime", 32'(result.peakTime), 32'(expRes.peakTime));
                end
                resCount++;
            end
        end
    end

    // every sample acked exactly once
    initial begin : ackCountProc
        forever begin
            @(negedge clk);
            if (!rst && smpAck) begin
                ackCount++;
            end
        end
    end

    initial begin : watchdogProc
        #(watchdogCycles * clkPeriod);
        $display("Timeout: run did not finish within %0d clock cycles", watchdogCycles);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
hdl/hisPkg.sv
hdl/binFolder.sv
hdl/hisBuilder.sv
hdl/peakDetector.sv
hdl/binRamArbiter.sv
hdl/binRam.sv
hdl/peakTop.sv
tests/peakTop_asserts.sv
tests/peakTopTb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module peakTopTb -f compile.f --Mdir obj_dir
	./obj_dir/VpeakTopTb | tee /dev/stderr | grep -q "Test passed"

clean:
	rm -rf obj_dir
